// ==== common/resadd_pkg.sv ====
`default_nettype none

package resadd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Single precision format
  ////////////////////////////////////////////////////////////////////////////

  // Field widths of an IEEE-754 binary32 word
  localparam int EXP_W  = 8;
  localparam int MANT_W = 23;

  // Exponent bias of binary32
  localparam int EXP_BIAS = 127;

  // Leaky slope of 1/8 done as an exponent decrement
  localparam logic [EXP_W-1:0] LEAKY_SHIFT = EXP_W'(3);

  // Float word, sign on top
  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exponent;
    logic [MANT_W-1:0] mantissa;
  } fp32_t;

  ////////////////////////////////////////////////////////////////////////////
  // Streams
  ////////////////////////////////////////////////////////////////////////////

  // One stream beat, strobe plus word
  typedef struct packed {
    logic  valid;
    fp32_t data;
  } beat_t;

  // Activation select, main path only
  typedef enum logic [1:0] {
    ACT_NONE  = 2'd0,
    ACT_RELU  = 2'd1,
    ACT_LEAKY = 2'd2
  } act_op_e;

endpackage

`default_nettype wire

// ==== hw/skip_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module skip_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                push,
  input  resadd_pkg::fp32_t   push_data,
  input  logic                pop,
  output resadd_pkg::beat_t   pop_beat
);

  import resadd_pkg::*;

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  // Skip word storage
  fp32_t mem [FIFO_DEPTH];

  // Pointers carry one extra wrap bit
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;
  logic            empty;
  logic            full;

  // Output register
  logic            pop_valid;
  fp32_t           pop_data;

  // Same wrap bit and address means empty, opposite wrap bit means full
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[ADDR_W-1:0]] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      pop_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Valid is the pop strobe one cycle late
      pop_valid <= pop;
    end
  end

  // Popped word lands next to its valid
  always_ff @(posedge clk) begin
    if (pop) begin
      pop_data <= mem[rd_ptr[ADDR_W-1:0]];
    end
  end

  assign pop_beat.valid = pop_valid;
  assign pop_beat.data  = pop_data;

  // Main element must never run ahead of its skip partner
  a_no_pop_empty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
    else $error("skip_fifo: pop while empty");

  // Producer keeps the occupancy within FIFO_DEPTH
  a_no_push_full: assert property (@(posedge clk) disable iff (reset) (push && full) |-> pop)
    else $error("skip_fifo: push while full");

endmodule

`default_nettype wire

// ==== hw/act_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module act_stage (
  input  logic                 clk,
  input  logic                 reset,
  input  resadd_pkg::act_op_e  op,
  input  resadd_pkg::beat_t    in_beat,
  output resadd_pkg::beat_t    out_beat
);

  import resadd_pkg::*;

  fp32_t in_word;
  fp32_t act_word;
  logic  out_valid;
  fp32_t out_data;

  ////////////////////////////////////////////////////////////////////////////
  // Activation function
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    in_word  = in_beat.data;
    act_word = in_word;
    // Denormal in, signed zero out
    if (in_word.exponent == '0) begin
      act_word.mantissa = '0;
    end
    case (op)
      ACT_NONE: begin
        act_word = act_word;
      end
      ACT_RELU: begin
        // Negatives and -0 clamp to +0
        if (act_word.sign) begin
          act_word = '0;
        end
      end
      ACT_LEAKY: begin
        if (act_word.sign) begin
          // Divide by 8 on the exponent, too small drops to -0
          if (act_word.exponent <= LEAKY_SHIFT) begin
            act_word = '{sign: 1'b1, exponent: '0, mantissa: '0};
          end else begin
            act_word.exponent = act_word.exponent - LEAKY_SHIFT;
          end
        end
      end
      default: begin
        act_word = act_word;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output register, one cycle
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_beat.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_beat.valid) begin
      out_data <= act_word;
    end
  end

  assign out_beat.valid = out_valid;
  assign out_beat.data  = out_data;

  // Opcode level comes from outside, unused code is illegal while data flows
  a_op_legal: assert property (@(posedge clk) disable iff (reset)
    in_beat.valid |-> op inside {ACT_NONE, ACT_RELU, ACT_LEAKY})
    else $error("act_stage: unused opcode with valid data");

endmodule

`default_nettype wire

// ==== fp_add/fp_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_add (
  input  logic               clk,
  input  logic               reset,
  input  resadd_pkg::beat_t  a_beat,
  input  resadd_pkg::beat_t  b_beat,
  output resadd_pkg::beat_t  sum_beat
);

  import resadd_pkg::*;

  // First exponent that would mean infinity
  localparam logic signed [9:0] EXP_LIMIT = 10'(2 * EXP_BIAS + 1);

  // Stage 1 logic, compare and align
  logic        in_valid;
  logic [30:0] a_mag;
  logic [30:0] b_mag;
  logic        swap;
  fp32_t       op_l;
  fp32_t       op_s;
  logic [7:0]  exp_diff;
  logic [26:0] sig_s_ext;
  logic [26:0] shifted;
  logic [26:0] lost_mask;
  logic        lost;
  logic [26:0] aligned;

  // Stage 1 registers
  logic        s1_valid;
  logic        s1_sign;
  logic        s1_sub;
  logic [7:0]  s1_exp;
  logic [26:0] s1_big;
  logic [26:0] s1_small;

  // Stage 2 registers
  logic        s2_valid;
  logic        s2_sign;
  logic        s2_sub;
  logic [7:0]  s2_exp;
  logic [27:0] s2_sum;

  // Stage 3 logic, normalize and round
  logic [4:0]        lz;
  logic [27:0]       norm;
  logic              guard;
  logic              sticky;
  logic              round_up;
  logic [24:0]       rounded;
  logic signed [9:0] exp_norm;
  fp32_t             result;

  // Stage 3 registers
  logic        s3_valid;
  fp32_t       s3_data;

  // Leading zeros of the 28 bit sum, 28 when all clear
  function automatic logic [4:0] count_lz(input logic [27:0] v);
    logic [4:0] n;
    logic       found;
    n     = 5'd0;
    found = 1'b0;
    for (int i = 27; i >= 0; i--) begin
      if (!found) begin
        if (v[i]) begin
          found = 1'b1;
        end else begin
          n = n + 5'd1;
        end
      end
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1
  ////////////////////////////////////////////////////////////////////////////

  assign in_valid = a_beat.valid & b_beat.valid;

  always_comb begin
    // Denormals count as zero magnitude
    a_mag = (a_beat.data.exponent == '0) ? '0 :
            {a_beat.data.exponent, a_beat.data.mantissa};
    b_mag = (b_beat.data.exponent == '0) ? '0 :
            {b_beat.data.exponent, b_beat.data.mantissa};
    swap  = (b_mag > a_mag);
    op_l  = swap ? b_beat.data : a_beat.data;
    op_s  = swap ? a_beat.data : b_beat.data;
    // Hidden bit plus 3 spare bits for guard, round, sticky
    sig_s_ext = (op_s.exponent != '0) ? {1'b1, op_s.mantissa, 3'b000} : '0;
    exp_diff  = op_l.exponent - op_s.exponent;
    // Big shifts just zero out, everything lands in sticky
    shifted   = sig_s_ext >> exp_diff;
    lost_mask = ~({27{1'b1}} << exp_diff);
    lost      = |(sig_s_ext & lost_mask);
    aligned   = {shifted[26:1], shifted[0] | lost};
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      s1_sign  <= op_l.sign;
      s1_sub   <= op_l.sign ^ op_s.sign;
      s1_exp   <= op_l.exponent;
      s1_big   <= (op_l.exponent != '0) ? {1'b1, op_l.mantissa, 3'b000} : '0;
      s1_small <= aligned;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2
  ////////////////////////////////////////////////////////////////////////////

  // Big operand first, so the difference never goes negative
  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_sign <= s1_sign;
      s2_sub  <= s1_sub;
      s2_exp  <= s1_exp;
      s2_sum  <= s1_sub ? ({1'b0, s1_big} - {1'b0, s1_small}) :
                          ({1'b0, s1_big} + {1'b0, s1_small});
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 3
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    lz   = count_lz(s2_sum);
    // Leading one moves to bit 27
    norm     = s2_sum << lz;
    guard    = norm[3];
    sticky   = |norm[2:0];
    // Nearest even, ties go to even lsb
    round_up = guard & (sticky | norm[4]);
    rounded  = {1'b0, norm[27:4]} + 25'(round_up);
    // Bit 27 sits one above the hidden bit position
    exp_norm = $signed({2'b00, s2_exp}) + 10'sd1 - $signed({5'b00000, lz}) +
               $signed({9'd0, rounded[24]});
    if (s2_sum == '0) begin
      // Exact cancellation is +0, only -0 plus -0 keeps the sign
      result = '{sign: s2_sign & ~s2_sub, exponent: '0, mantissa: '0};
    end else if (exp_norm <= 10'sd0) begin
      // Underflow flushed
      result = '{sign: s2_sign, exponent: '0, mantissa: '0};
    end else begin
      result.sign     = s2_sign;
      result.exponent = exp_norm[7:0];
      result.mantissa = rounded[24] ? rounded[23:1] : rounded[22:0];
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      s3_data <= result;
    end
  end

  // Valid pipe
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  assign sum_beat.valid = s3_valid;
  assign sum_beat.data  = s3_data;

  // Register path and FIFO path stay in lockstep
  a_valid_match: assert property (@(posedge clk) disable iff (reset)
    a_beat.valid == b_beat.valid)
    else $error("fp_add: operand valids differ");

  // Overflow lies outside the supported range
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    (s2_valid && s2_sum != '0) |-> exp_norm < EXP_LIMIT)
    else $error("fp_add: exponent overflow");

endmodule

`default_nettype wire

// ==== hw/residual_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module residual_add #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                 clk,
  input  logic                 reset,
  input  resadd_pkg::act_op_e  act_op,
  input  resadd_pkg::beat_t    main_in,
  input  resadd_pkg::beat_t    skip_in,
  output resadd_pkg::beat_t    sum_out
);

  import resadd_pkg::*;

  // Aligned operands for the adder
  beat_t skip_beat;
  beat_t act_beat;

  ////////////////////////////////////////////////////////////////////////////
  // Skip path, buffered until the main partner shows up
  ////////////////////////////////////////////////////////////////////////////

  // Main arrival pops its own skip element
  skip_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_skip_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (skip_in.valid),
    .push_data (skip_in.data),
    .pop       (main_in.valid),
    .pop_beat  (skip_beat)
  );

  // Main path, one register with the activation
  act_stage u_act_stage (
    .clk      (clk),
    .reset    (reset),
    .op       (act_op),
    .in_beat  (main_in),
    .out_beat (act_beat)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Combine
  ////////////////////////////////////////////////////////////////////////////

  fp_add u_fp_add (
    .clk      (clk),
    .reset    (reset),
    .a_beat   (act_beat),
    .b_beat   (skip_beat),
    .sum_beat (sum_out)
  );

endmodule

`default_nettype wire

// ==== dv/fp_ref.svh ====
`ifndef FP_REF_SVH
`define FP_REF_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model of the residual-add datapath
////////////////////////////////////////////////////////////////////////////

// Activation on the main value, denormals read as signed zero
function automatic fp32_t apply_activation(input act_op_e op, input fp32_t x);
  fp32_t v;
  v = x;
  if (v.exponent == 8'd0) begin
    v.mantissa = 23'd0;
  end
  // ReLU keeps only the non-negative half, -0 included
  if (op == ACT_RELU && v.sign) begin
    v = '{sign: 1'b0, exponent: 8'd0, mantissa: 23'd0};
  end
  // Slope 1/8 on negatives, too small becomes -0
  if (op == ACT_LEAKY && v.sign) begin
    if (v.exponent > LEAKY_SHIFT) begin
      v.exponent = v.exponent - LEAKY_SHIFT;
    end else begin
      v = '{sign: 1'b1, exponent: 8'd0, mantissa: 23'd0};
    end
  end
  return v;
endfunction

// Exact sum in a wide integer, then one round to nearest even
function automatic fp32_t add_rounded(input fp32_t a, input fp32_t b);
  logic [255:0] mag_a;
  logic [255:0] mag_b;
  logic [255:0] total;
  logic [255:0] kept;
  logic [255:0] dropped;
  logic [255:0] half;
  int           exp_a;
  int           exp_b;
  int           exp_lo;
  int           top;
  int           drop;
  int           exp_out;
  logic         sign_out;
  fp32_t        res;
  // Significand with hidden bit, zero for zero and denormal
  mag_a = (a.exponent == 8'd0) ? 256'd0 : 256'({1'b1, a.mantissa});
  mag_b = (b.exponent == 8'd0) ? 256'd0 : 256'({1'b1, b.mantissa});
  exp_a = a.exponent;
  exp_b = b.exponent;
  // Sum of two zeros is negative only when both are
  if (mag_a == 256'd0 && mag_b == 256'd0) begin
    return '{sign: a.sign & b.sign, exponent: 8'd0, mantissa: 23'd0};
  end
  if (mag_a == 256'd0) begin
    exp_a = exp_b;
  end
  if (mag_b == 256'd0) begin
    exp_b = exp_a;
  end
  // Common scale at the smaller exponent, nothing is lost here
  exp_lo = (exp_a < exp_b) ? exp_a : exp_b;
  mag_a  = mag_a << (exp_a - exp_lo);
  mag_b  = mag_b << (exp_b - exp_lo);
  if (a.sign == b.sign) begin
    total    = mag_a + mag_b;
    sign_out = a.sign;
  end else if (mag_a >= mag_b) begin
    total    = mag_a - mag_b;
    sign_out = a.sign;
  end else begin
    total    = mag_b - mag_a;
    sign_out = b.sign;
  end
  // Exact cancellation
  if (total == 256'd0) begin
    return '{sign: 1'b0, exponent: 8'd0, mantissa: 23'd0};
  end
  top = 0;
  for (int i = 0; i < 256; i++) begin
    if (total[i]) begin
      top = i;
    end
  end
  if (top > 23) begin
    drop    = top - 23;
    kept    = total >> drop;
    dropped = total & ((256'd1 << drop) - 256'd1);
    half    = 256'd1 << (drop - 1);
    if (dropped > half || (dropped == half && kept[0])) begin
      kept = kept + 256'd1;
    end
    // Round carried into a new leading bit
    if (kept[24]) begin
      kept = kept >> 1;
      top  = top + 1;
    end
  end else begin
    kept = total << (23 - top);
  end
  exp_out = exp_lo + top - 23;
  // Underflow goes to signed zero
  if (exp_out <= 0) begin
    return '{sign: sign_out, exponent: 8'd0, mantissa: 23'd0};
  end
  res.sign     = sign_out;
  res.exponent = exp_out[7:0];
  res.mantissa = kept[22:0];
  return res;
endfunction

`endif

// ==== dv/tb_residual_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_residual_add;

  import resadd_pkg::*;

  `include "fp_ref.svh"

  localparam int FIFO_DEPTH  = 16;
  localparam int PHASE_ITEMS = 300;
  localparam int DRAIN_LIMIT = 100;

  // Scoreboard entry holding the expected word and its output edge
  typedef struct packed {
    logic [31:0] data;
    logic [31:0] cycle;
  } expect_t;

  logic    clk;
  logic    reset;
  act_op_e act_op;
  beat_t   main_in;
  beat_t   skip_in;
  beat_t   sum_out;

  integer  seed;
  int      cycle = 0;
  expect_t exp_q[$];
  fp32_t   skip_q[$];
  expect_t head;

  residual_add #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_residual_add (
    .clk     (clk),
    .reset   (reset),
    .act_op  (act_op),
    .main_in (main_in),
    .skip_in (skip_in),
    .sum_out (sum_out)
  );

  always #10 clk = ~clk;

  // Edge counter that holds k after rising edge k
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Random operands
  ////////////////////////////////////////////////////////////////////////////

  function automatic int uniform_int(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % 32'(hi - lo + 1));
  endfunction

  function automatic fp32_t random_float(input int exp_lo, input int exp_hi);
    fp32_t v;
    v.sign     = 1'(uniform_int(0, 1));
    v.exponent = 8'(uniform_int(exp_lo, exp_hi));
    v.mantissa = 23'($random(seed));
    return v;
  endfunction

  // Mostly normal range with a few zeros and tiny values
  function automatic fp32_t skip_operand();
    int kind;
    kind = uniform_int(0, 19);
    if (kind == 0) begin
      return '{sign: 1'(uniform_int(0, 1)), exponent: 8'd0, mantissa: 23'd0};
    end
    if (kind < 3) begin
      return random_float(0, 4);
    end
    return random_float(64, 190);
  endfunction

  // Main value shaped against its skip partner
  function automatic fp32_t main_operand(input fp32_t partner);
    fp32_t v;
    int    kind;
    kind = uniform_int(0, 15);
    v    = random_float(64, 190);
    case (kind)
      0: v = '{sign: 1'(uniform_int(0, 1)), exponent: 8'd0, mantissa: 23'd0};
      1: begin
        // Exact negation cancels to +0
        v      = partner;
        v.sign = ~partner.sign;
      end
      2: begin
        // Near cancellation where tiny partners flush
        v               = partner;
        v.sign          = ~partner.sign;
        v.mantissa[3:0] = 4'(uniform_int(0, 15));
      end
      3: begin
        // Wide exponent gap
        if (partner.exponent >= 8'd127) begin
          v.exponent = 8'(int'(partner.exponent) - uniform_int(25, 60));
        end else begin
          v.exponent = 8'(int'(partner.exponent) + uniform_int(25, 60));
        end
      end
      4: v = random_float(0, 4);
      5, 6: begin
        // Close exponents give frequent ties
        v.exponent = 8'(int'(partner.exponent) + uniform_int(0, 2));
      end
      default: v = v;
    endcase
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > DRAIN_LIMIT) begin
        fail_run("Timed out waiting for the adder pipeline to drain");
      end
    end
  endtask

  task automatic run_phase(input act_op_e op, input int count);
    int      skips_sent;
    int      mains_sent;
    int      occ;
    int      mode;
    int      hold;
    int      spins;
    logic    do_skip;
    logic    do_main;
    fp32_t   main_val;
    fp32_t   skip_val;
    expect_t item;
    skips_sent = 0;
    mains_sent = 0;
    occ        = 0;
    hold       = 0;
    mode       = 0;
    spins      = 0;
    @(posedge clk);
    act_op <= op;
    while (mains_sent < count) begin
      @(posedge clk);
      spins++;
      if (spins > count * 50) begin
        fail_run("Stimulus loop made no progress");
      end
      // Traffic mode changes every few cycles
      if (hold == 0) begin
        mode = uniform_int(0, 3);
        hold = uniform_int(4, 40);
      end
      hold--;
      case (mode)
        0: begin
          do_skip = 1'(uniform_int(0, 1));
          do_main = 1'(uniform_int(0, 1));
        end
        // Fill the FIFO
        1: begin
          do_skip = 1'b1;
          do_main = 1'b0;
        end
        // Back-to-back on both streams
        2: begin
          do_skip = 1'b1;
          do_main = 1'b1;
        end
        default: begin
          do_skip = 1'b0;
          do_main = 1'b1;
        end
      endcase
      if (skips_sent == count) begin
        do_skip = 1'b0;
        do_main = 1'b1;
      end
      // Main only once its partner sits in the FIFO
      if (occ == 0) begin
        do_main = 1'b0;
      end
      if (occ - int'(do_main) + 1 > FIFO_DEPTH) begin
        do_skip = 1'b0;
      end
      main_in.valid <= do_main;
      if (do_main) begin
        main_val = main_operand(skip_q[0]);
        main_in.data <= main_val;
        item.data = add_rounded(apply_activation(op, main_val), skip_q.pop_front());
        // Counter still shows the last edge and the DUT samples on the next one
        // Sum is sampled four edges after that
        item.cycle = 32'(cycle + 2 + 4);
        exp_q.push_back(item);
        mains_sent++;
      end
      skip_in.valid <= do_skip;
      if (do_skip) begin
        skip_val = skip_operand();
        skip_in.data <= skip_val;
        skip_q.push_back(skip_val);
        skips_sent++;
      end
      occ = occ - int'(do_main) + int'(do_skip);
    end
    @(posedge clk);
    main_in.valid <= 1'b0;
    skip_in.valid <= 1'b0;
    wait_drain();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!reset && $isunknown(sum_out.valid)) begin
      fail_run("sum_out.valid is unknown after reset");
    end
    if (!reset && sum_out.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        fail_run("Output beat arrived while no sum was pending");
      end else begin
        head = exp_q.pop_front();
        check_value("sum_out.data", sum_out.data, head.data);
        // Next rising edge samples the beat
        check_value("sum_out.valid cycle", 32'(cycle + 1), head.cycle);
      end
    end
  end

  initial begin
    clk     = 1'b0;
    reset   = 1'b1;
    act_op  = ACT_NONE;
    main_in = '0;
    skip_in = '0;
    seed    = 32'hd5a4_4e54;
    // Three reset edges with the output held low
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      if (i == 2) begin
        reset <= 1'b0;
      end
      @(negedge clk);
      check_value("sum_out.valid", 32'(sum_out.valid), 32'd0);
    end
    run_phase(ACT_NONE, PHASE_ITEMS);
    run_phase(ACT_RELU, PHASE_ITEMS);
    run_phase(ACT_LEAKY, PHASE_ITEMS);
    // Idle tail catches stray output beats
    repeat (10) @(negedge clk);
    if (exp_q.size() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      fail_run("Scoreboard still holds pending sums at the end");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+dv
common/resadd_pkg.sv
hw/skip_fifo.sv
hw/act_stage.sv
fp_add/fp_add.sv
hw/residual_add.sv
dv/tb_residual_add.sv

// ==== Bender.yml ====
package:
  name: residual_add

sources:
  - files:
      - common/resadd_pkg.sv
      - hw/skip_fifo.sv
      - hw/act_stage.sv
      - fp_add/fp_add.sv
      - hw/residual_add.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_residual_add.sv
